// File: isq_settings.svh
/*
 * issue queue settings
 * queue depth, dispatch width, instruction and index widths,
 * plus derived line widths and line bit positions
 */

`ifndef ISQ_SETTINGS_SVH
`define ISQ_SETTINGS_SVH

// number of queue lines
`define ISQ_DEPTH 16

// dispatch ports, also lines per group
`define ISQ_PORTS 4

// instruction word width, top bit is the instruction valid bit
`define ISQ_INST_W 16

// line index width
`define ISQ_IDX_W 4

// groups of lines filled by one dispatch
`define ISQ_GROUPS (`ISQ_DEPTH / `ISQ_PORTS)

// stored line is {valid, wait, instruction}
`define ISQ_LIN_W (`ISQ_INST_W + 2)
`define ISQ_VLD_BIT (`ISQ_INST_W + 1)
`define ISQ_WAT_BIT (`ISQ_INST_W)

// output bus word is {index, line}
`define ISQ_OUT_W (`ISQ_IDX_W + `ISQ_LIN_W)

`endif

// File: isq_pkg.sv
/*
 * issue queue package
 * shared word and vector types plus the lowest set bit picker
 */

`default_nettype none

`include "isq_settings.svh"

package isq_pkg;

   // one instruction word
   typedef logic [`ISQ_INST_W-1:0] inst_t;

   // stored line without index, {valid, wait, instruction}
   typedef logic [`ISQ_LIN_W-1:0] line_t;

   // output bus word, {index, valid, wait, instruction}
   typedef logic [`ISQ_OUT_W-1:0] out_line_t;

   // one bit per queue line
   typedef logic [`ISQ_DEPTH-1:0] line_vec_t;

   //////////////////////////////
   // lowest set bit
   //////////////////////////////
   // result is {found, position}, position is zero when nothing is set
   function automatic logic [`ISQ_IDX_W:0] lowest_set(input line_vec_t vec);
      logic [`ISQ_IDX_W:0] res;
      res = '0;
      // scan from the top so the lowest hit lands last
      for (int i = `ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (vec[i])
            res = {1'b1, i[`ISQ_IDX_W-1:0]};
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// File: isq_lin.sv
/*
 * issue queue line
 * holds one instruction with its valid and wait bits
 * priority is flush, then write, then wakeup
 */

`default_nettype none
`timescale 1ns/100ps

`include "isq_settings.svh"

module isq_lin
   import isq_pkg::*;
(
   input  wire   clk,
   input  wire   rst_n,
   input  wire   en_i,
   input  wire   flush_i,
   input  wire   clr_wat_i,
   input  line_t lin_i,
   output line_t lin_o
);

   // state bits
   logic vld_q;
   logic wat_q;

   // stored instruction
   inst_t inst_q;

   //////////////////////////////
   // valid and wait state
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         vld_q <= 1'b0;
         wat_q <= 1'b0;
      end
      // flush drops the line outright
      else if (flush_i)
      begin
         vld_q <= 1'b0;
         wat_q <= 1'b0;
      end
      // new line, both bits follow the instruction valid bit
      else if (en_i)
      begin
         vld_q <= lin_i[`ISQ_VLD_BIT];
         wat_q <= lin_i[`ISQ_WAT_BIT];
      end
      // wakeup only touches a live line
      else if (clr_wat_i && vld_q)
         wat_q <= 1'b0;
   end

   // instruction payload
   always_ff @(posedge clk)
   begin
      if (en_i && !flush_i)
         inst_q <= lin_i[`ISQ_INST_W-1:0];
   end

   assign lin_o = {vld_q, wat_q, inst_q};

endmodule

`default_nettype wire

// File: isq.sv
/*
 * issue queue array
 * spreads dispatch words over the lines, holds the lines and
 * builds the output bus with each line index in the top bits
 */

`default_nettype none
`timescale 1ns/100ps

`include "isq_settings.svh"

module isq
   import isq_pkg::*;
(
   input  wire                          clk,
   input  wire                          rst_n,
   input  inst_t     [`ISQ_PORTS-1:0]   disp_inst_i,
   input  line_vec_t                    lin_en_i,
   input  line_vec_t                    wake_i,
   input  line_vec_t                    flush_i,
   input  line_vec_t                    iss_flush_i,
   output out_line_t [`ISQ_DEPTH-1:0]   isq_out_o
);

   // per line input and output words
   line_t lin_in [`ISQ_DEPTH];
   line_t lin_out [`ISQ_DEPTH];

   // external flush plus issue flush
   line_vec_t fls;

   assign fls = flush_i | iss_flush_i;

   //////////////////////////////
   // line inputs
   //////////////////////////////
   // line g*ports+p takes port p
   // valid bit prefixed twice, once as valid and once as wait
   for (genvar i = 0; i < `ISQ_DEPTH; i++)
   begin : g_lin_in
      assign lin_in[i] = {disp_inst_i[i % `ISQ_PORTS][`ISQ_INST_W-1],
                          disp_inst_i[i % `ISQ_PORTS][`ISQ_INST_W-1],
                          disp_inst_i[i % `ISQ_PORTS]};
   end

   //////////////////////////////
   // line array
   //////////////////////////////
   for (genvar i = 0; i < `ISQ_DEPTH; i++)
   begin : g_lin
      isq_lin u_lin (
         .clk       (clk),
         .rst_n     (rst_n),
         .en_i      (lin_en_i[i]),
         .flush_i   (fls[i]),
         .clr_wat_i (wake_i[i]),
         .lin_i     (lin_in[i]),
         .lin_o     (lin_out[i])
      );
   end

   //////////////////////////////
   // output bus
   //////////////////////////////
   for (genvar i = 0; i < `ISQ_DEPTH; i++)
   begin : g_out
      // constant line index
      localparam logic [`ISQ_IDX_W-1:0] LIN_IDX = i;

      // index goes on top, the selector parses the bus by it
      assign isq_out_o[i] = {LIN_IDX, lin_out[i]};
   end

endmodule

`default_nettype wire

// File: isq_alloc.sv
/*
 * issue queue allocator
 * finds the lowest group with all lines free, raises its
 * write enables on dispatch and flags a full queue
 */

`default_nettype none
`timescale 1ns/100ps

`include "isq_settings.svh"

module isq_alloc
   import isq_pkg::*;
(
   input  wire       disp_i,
   input  line_vec_t valid_i,
   output line_vec_t lin_en_o,
   output logic      full_o
);

   // one flag per group, all lines of the group invalid
   logic [`ISQ_GROUPS-1:0] grp_free;

   // group flags widened for the picker
   line_vec_t grp_vec;

   // {found, group}
   logic [`ISQ_IDX_W:0] pick;

   //////////////////////////////
   // group free flags
   //////////////////////////////
   always_comb
   begin
      for (int g = 0; g < `ISQ_GROUPS; g++)
         grp_free[g] = ~|valid_i[g*`ISQ_PORTS +: `ISQ_PORTS];
   end

   // upper bits stay clear
   always_comb
   begin
      grp_vec = '0;
      grp_vec[`ISQ_GROUPS-1:0] = grp_free;
   end

   assign pick = lowest_set(grp_vec);

   // full when no group is entirely free
   assign full_o = ~|grp_free;

   //////////////////////////////
   // write enables
   //////////////////////////////
   // chosen group gets all its lines, only while dispatching
   always_comb
   begin
      lin_en_o = '0;
      for (int g = 0; g < `ISQ_GROUPS; g++)
      begin
         if (disp_i && pick[`ISQ_IDX_W] && (pick[`ISQ_IDX_W-1:0] == g))
            lin_en_o[g*`ISQ_PORTS +: `ISQ_PORTS] = '1;
      end
   end

endmodule

`default_nettype wire

// File: isq_sel.sv
/*
 * issue selector
 * picks the lowest ready line, frees it with a one-hot flush
 * and registers the issued index and instruction
 */

`default_nettype none
`timescale 1ns/100ps

`include "isq_settings.svh"

module isq_sel
   import isq_pkg::*;
(
   input  wire                          clk,
   input  wire                          rst_n,
   input  out_line_t [`ISQ_DEPTH-1:0]   isq_out_i,
   output line_vec_t                    iss_flush_o,
   output logic                         issue_valid_o,
   output logic      [`ISQ_IDX_W-1:0]   issue_idx_o,
   output inst_t                        issue_inst_o
);

   // valid and not waiting
   line_vec_t rdy;

   // {found, line}
   logic [`ISQ_IDX_W:0] pick;

   // bus word of the picked line
   out_line_t pick_word;

   //////////////////////////////
   // ready vector and pick
   //////////////////////////////
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
         rdy[i] = isq_out_i[i][`ISQ_VLD_BIT] & ~isq_out_i[i][`ISQ_WAT_BIT];
   end

   assign pick = lowest_set(rdy);

   assign pick_word = isq_out_i[pick[`ISQ_IDX_W-1:0]];

   // one-hot flush, the line is cleared at the issue edge
   always_comb
   begin
      iss_flush_o = '0;
      if (pick[`ISQ_IDX_W])
         iss_flush_o[pick[`ISQ_IDX_W-1:0]] = 1'b1;
   end

   //////////////////////////////
   // issue register
   //////////////////////////////
   // valid for exactly one cycle per issued line
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         issue_valid_o <= 1'b0;
      else
         issue_valid_o <= pick[`ISQ_IDX_W];
   end

   // index comes from the bus word, not the picker
   always_ff @(posedge clk)
   begin
      if (pick[`ISQ_IDX_W])
      begin
         issue_idx_o  <= pick_word[`ISQ_OUT_W-1 -: `ISQ_IDX_W];
         issue_inst_o <= pick_word[`ISQ_INST_W-1:0];
      end
   end

endmodule

`default_nettype wire

// File: isq_top.sv
/*
 * issue queue top
 * allocator, line array and issue selector
 */

`default_nettype none
`timescale 1ns/100ps

`include "isq_settings.svh"

module isq_top
   import isq_pkg::*;
(
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          disp_i,
   input  inst_t     [`ISQ_PORTS-1:0]   disp_inst_i,
   input  line_vec_t                    wake_i,
   input  line_vec_t                    flush_i,
   output logic                         full_o,
   output logic                         issue_valid_o,
   output logic      [`ISQ_IDX_W-1:0]   issue_idx_o,
   output inst_t                        issue_inst_o
);

   // internal nets
   out_line_t [`ISQ_DEPTH-1:0] isq_out;
   line_vec_t                  valid;
   line_vec_t                  lin_en;
   line_vec_t                  iss_flush;

   // valid bits off the bus for the allocator
   for (genvar i = 0; i < `ISQ_DEPTH; i++)
   begin : g_vld
      assign valid[i] = isq_out[i][`ISQ_VLD_BIT];
   end

   //////////////////////////////
   // blocks
   //////////////////////////////
   isq_alloc u_alloc (
      .disp_i   (disp_i),
      .valid_i  (valid),
      .lin_en_o (lin_en),
      .full_o   (full_o)
   );

   isq u_isq (
      .clk         (clk),
      .rst_n       (rst_n),
      .disp_inst_i (disp_inst_i),
      .lin_en_i    (lin_en),
      .wake_i      (wake_i),
      .flush_i     (flush_i),
      .iss_flush_i (iss_flush),
      .isq_out_o   (isq_out)
   );

   isq_sel u_sel (
      .clk           (clk),
      .rst_n         (rst_n),
      .isq_out_i     (isq_out),
      .iss_flush_o   (iss_flush),
      .issue_valid_o (issue_valid_o),
      .issue_idx_o   (issue_idx_o),
      .issue_inst_o  (issue_inst_o)
   );

endmodule

`default_nettype wire

// File: tb_isq.sv
/*
 * issue queue testbench
 * reference model of line state, concurrent assertions against it,
 * directed dispatch, wakeup, flush and full scenarios
 */

`default_nettype none
`timescale 1ns/100ps

`include "isq_settings.svh"

module tb_isq
   import isq_pkg::*;
();

   localparam int TIMEOUT = 20;

   // DUT side
   logic                      clk = 1'b0;
   logic                      rst_n;
   logic                      disp_i;
   inst_t [`ISQ_PORTS-1:0]    disp_inst_i;
   line_vec_t                 wake_i;
   line_vec_t                 flush_i;
   logic                      full_o;
   logic                      issue_valid_o;
   logic [`ISQ_IDX_W-1:0]     issue_idx_o;
   inst_t                     issue_inst_o;

   // reference model state
   line_vec_t                 m_vld;
   line_vec_t                 m_wat;
   inst_t                     m_inst [`ISQ_DEPTH];
   logic                      m_iss_valid;
   logic [`ISQ_IDX_W-1:0]     m_iss_idx;
   inst_t                     m_iss_inst;
   logic                      m_full;

   // words handed to each line at dispatch
   inst_t                     tb_disp [`ISQ_DEPTH];
   int                        seed;

   always #4 clk = ~clk;

   isq_top uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .disp_i        (disp_i),
      .disp_inst_i   (disp_inst_i),
      .wake_i        (wake_i),
      .flush_i       (flush_i),
      .full_o        (full_o),
      .issue_valid_o (issue_valid_o),
      .issue_idx_o   (issue_idx_o),
      .issue_inst_o  (issue_inst_o)
   );

   //////////////////////////////
   // error reporting
   //////////////////////////////
   task automatic stop_failed();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, sig, exp, got);
      stop_failed();
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      stop_failed();
   endtask

   task automatic check_val(input string sig, input logic [31:0] exp,
                            input logic [31:0] got);
      assert (got === exp)
      else report_mismatch(sig, exp, got);
   endtask

   //////////////////////////////
   // reference model
   //////////////////////////////
   // lowest group with all four lines free, -1 when full
   function automatic int free_group(input line_vec_t vld);
      int g;
      free_group = -1;
      for (g = `ISQ_GROUPS - 1; g >= 0; g--)
      begin
         if (vld[g*`ISQ_PORTS +: `ISQ_PORTS] == '0)
            free_group = g;
      end
   endfunction

   function automatic line_vec_t lines_of(input int g);
      lines_of = '0;
      lines_of[g*`ISQ_PORTS +: `ISQ_PORTS] = '1;
   endfunction

   assign m_full = (free_group(m_vld) < 0);

   always @(posedge clk or negedge rst_n)
   begin : model_update
      line_vec_t rdy;
      line_vec_t wr;
      line_vec_t fl;
      int        r;
      int        g;
      if (!rst_n)
      begin
         m_vld       <= '0;
         m_wat       <= '0;
         m_iss_valid <= 1'b0;
      end
      else
      begin
         rdy = m_vld & ~m_wat;
         r = -1;
         for (int i = 0; i < `ISQ_DEPTH; i++)
            if (r < 0 && rdy[i])
               r = i;
         // dropped while full
         g = free_group(m_vld);
         wr = '0;
         if (disp_i && g >= 0)
            wr = lines_of(g);
         // issued line is freed at the same edge
         fl = flush_i;
         if (r >= 0)
            fl[r] = 1'b1;
         for (int i = 0; i < `ISQ_DEPTH; i++)
         begin
            if (fl[i])
            begin
               m_vld[i] <= 1'b0;
               m_wat[i] <= 1'b0;
            end
            else if (wr[i])
            begin
               m_vld[i]  <= disp_inst_i[i % `ISQ_PORTS][`ISQ_INST_W-1];
               m_wat[i]  <= disp_inst_i[i % `ISQ_PORTS][`ISQ_INST_W-1];
               m_inst[i] <= disp_inst_i[i % `ISQ_PORTS];
            end
            else if (wake_i[i] && m_vld[i])
               m_wat[i] <= 1'b0;
         end
         m_iss_valid <= (r >= 0);
         if (r >= 0)
         begin
            m_iss_idx  <= r[`ISQ_IDX_W-1:0];
            m_iss_inst <= m_inst[r];
         end
      end
   end

   //////////////////////////////
   // DUT against model
   //////////////////////////////
   a_iss_valid: assert property (@(posedge clk) disable iff (!rst_n)
      issue_valid_o == m_iss_valid)
      else report_mismatch("issue_valid_o", $sampled(m_iss_valid), $sampled(issue_valid_o));

   a_iss_idx: assert property (@(posedge clk) disable iff (!rst_n)
      m_iss_valid |-> issue_idx_o == m_iss_idx)
      else report_mismatch("issue_idx_o", $sampled(m_iss_idx), $sampled(issue_idx_o));

   a_iss_inst: assert property (@(posedge clk) disable iff (!rst_n)
      m_iss_valid |-> issue_inst_o == m_iss_inst)
      else report_mismatch("issue_inst_o", $sampled(m_iss_inst), $sampled(issue_inst_o));

   a_full: assert property (@(posedge clk) disable iff (!rst_n)
      full_o == m_full)
      else report_mismatch("full_o", $sampled(m_full), $sampled(full_o));

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////
   // inputs are held for one edge, then cleared on the falling edge
   task automatic step();
      @(negedge clk);
      disp_i  = 1'b0;
      wake_i  = '0;
      flush_i = '0;
   endtask

   task automatic idle(input int n);
      repeat (n) step();
   endtask

   task automatic dispatch(output int grp);
      int    rnd;
      inst_t w;
      grp = free_group(m_vld);
      disp_i = 1'b1;
      for (int p = 0; p < `ISQ_PORTS; p++)
      begin
         rnd = $random(seed);
         w = rnd[`ISQ_INST_W-1:0];
         // payload always a live instruction
         w[`ISQ_INST_W-1] = 1'b1;
         disp_inst_i[p] = w;
         if (grp >= 0)
            tb_disp[grp*`ISQ_PORTS + p] = w;
      end
      step();
   endtask

   task automatic wake(input line_vec_t v);
      wake_i = v;
      step();
   endtask

   task automatic flush(input line_vec_t v);
      flush_i = v;
      step();
   endtask

   // next issue, checked for latency, index and payload
   task automatic wait_issue(input int exp_idx, input int exp_lat);
      int cnt;
      cnt = 0;
      do
      begin
         @(negedge clk);
         cnt++;
      end
      while (!issue_valid_o && cnt < TIMEOUT);
      if (!issue_valid_o)
         report_timeout("no issue seen while a ready line was expected");
      else
      begin
         check_val("issue latency", exp_lat, cnt);
         check_val("issue_idx_o", exp_idx, issue_idx_o);
         check_val("issue_inst_o", tb_disp[exp_idx], issue_inst_o);
      end
   endtask

   task automatic wait_full(input logic lvl);
      int cnt;
      cnt = 0;
      while (full_o !== lvl && cnt < TIMEOUT)
      begin
         @(negedge clk);
         cnt++;
      end
      if (full_o !== lvl)
         report_timeout("full_o never reached the expected level");
   endtask

   //////////////////////////////
   // scenarios
   //////////////////////////////
   initial
   begin : stim
      int        ga;
      int        gb;
      int        gc;
      seed        = 40;
      rst_n       = 1'b0;
      disp_i      = 1'b0;
      disp_inst_i = '0;
      wake_i      = '0;
      flush_i     = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // quiet after reset
      check_val("issue_valid_o", 0, issue_valid_o);
      check_val("full_o", 0, full_o);
      idle(4);

      // waiting lines hold until woken, then one edge to issue
      dispatch(ga);
      idle(3);
      wake(16'h0001 << (ga*`ISQ_PORTS + 2));
      wait_issue(ga*`ISQ_PORTS + 2, 1);

      // several woken at once go out in index order
      wake(lines_of(ga));
      wait_issue(ga*`ISQ_PORTS + 0, 1);
      wait_issue(ga*`ISQ_PORTS + 1, 1);
      wait_issue(ga*`ISQ_PORTS + 3, 1);

      // flushed group never issues and is reused
      dispatch(ga);
      dispatch(gb);
      flush(lines_of(ga));
      wake(lines_of(ga) | lines_of(gb));
      for (int p = 0; p < `ISQ_PORTS; p++)
         wait_issue(gb*`ISQ_PORTS + p, 1);
      dispatch(gc);
      check_val("reused group", ga, gc);
      wake(lines_of(gc));
      for (int p = 0; p < `ISQ_PORTS; p++)
         wait_issue(gc*`ISQ_PORTS + p, 1);

      // fill up, then one more dispatch is dropped
      repeat (`ISQ_GROUPS) dispatch(ga);
      wait_full(1'b1);
      dispatch(gb);
      idle(2);
      check_val("full_o", 1, full_o);

      // lowest group still holds its own words, issuing it lowers full
      wake(lines_of(0));
      for (int p = 0; p < `ISQ_PORTS; p++)
         wait_issue(p, 1);
      wait_full(1'b0);

      // issued group is the lowest free one again
      dispatch(gb);
      check_val("reused group", 0, gb);
      wait_full(1'b1);

      // flushing a whole group lowers full as well
      flush(lines_of(2));
      wait_full(1'b0);
      dispatch(gc);
      check_val("reused group", 2, gc);
      wake(lines_of(gc));
      for (int p = 0; p < `ISQ_PORTS; p++)
         wait_issue(gc*`ISQ_PORTS + p, 1);
      flush('1);
      idle(3);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
isq_pkg.sv
isq_lin.sv
isq.sv
isq_alloc.sv
isq_sel.sv
isq_top.sv
tb_isq.sv
